// ==== Makefile ====
# Verilator build and run of the AXI4-Lite ALU testbench

TOP := alu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o V$(TOP)

# Pass only when the simulation printed the pass message
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test passed"

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+source
source/alu_pkg.sv
source/alu_shifter.sv
source/alu_step_counter.sv
source/alu_sequencer.sv
source/alu_exec_datapath.sv
source/alu_axil_regs.sv
source/alu_top.sv
tb/alu_properties.sv
tb/alu_tb.sv

// ==== source/alu_axil_regs.sv ====
/* AXI4-Lite register block, one transaction outstanding per channel.
   CONTROL writes while busy are dropped with SLVERR; operand lanes follow wstrb. */
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_axil_regs import alu_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  axil_req_t   axil_req,
    output axil_rsp_t   axil_rsp,
    input  logic        busy,
    input  logic        finish,
    input  alu_result_t result,
    output logic        start,
    output alu_cmd_t    cmd
);
    logic                    wr_ready;
    logic                    wr_en;
    logic                    ctrl_wr;
    logic [1:0]              wr_resp;
    logic                    bvalid;
    logic [1:0]              bresp;
    logic                    ar_ready;
    logic                    rd_en;
    logic [`AXIL_DATA_W-1:0] rd_data;
    logic [1:0]              rd_resp;
    logic                    rvalid;
    logic [`AXIL_DATA_W-1:0] rdata;
    logic [1:0]              rresp;
    logic                    done;
    alu_word_t               operand_a;
    operand_b_u              operand_b;
    alu_result_t             res_q;

    assign wr_en = wr_ready && axil_req.awvalid && axil_req.wvalid;
    assign rd_en = ar_ready && axil_req.arvalid;

    // Write address decode, CONTROL is refused while an operation runs
    always_comb begin
        wr_resp = `AXI_RESP_SLVERR;
        ctrl_wr = 1'b0;
        case (axil_req.awaddr)
            `REG_OPERAND_A, `REG_OPERAND_B: wr_resp = `AXI_RESP_OKAY;
            `REG_CONTROL: begin
                if (!busy) begin
                    wr_resp = `AXI_RESP_OKAY;
                    ctrl_wr = 1'b1;
                end
            end
            default: wr_resp = `AXI_RESP_SLVERR;
        endcase
    end

    always_comb begin
        rd_data = '0;
        rd_resp = `AXI_RESP_OKAY;
        case (axil_req.araddr)
            `REG_OPERAND_A: rd_data = `AXIL_DATA_W'(operand_a);
            `REG_OPERAND_B: rd_data = `AXIL_DATA_W'(operand_b.value);
            `REG_CONTROL:   rd_data = `AXIL_DATA_W'(cmd.op);
            `REG_STATUS:    rd_data = `AXIL_DATA_W'({res_q.div_by_zero, done, busy});
            `REG_RESULT_LO: rd_data = `AXIL_DATA_W'(res_q.lo);
            `REG_RESULT_HI: rd_data = `AXIL_DATA_W'(res_q.hi);
            default:        rd_resp = `AXI_RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= `AXI_RESP_OKAY;
            start    <= 1'b0;
            ar_ready <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= `AXI_RESP_OKAY;
        end else begin
            // Ready pulses for a single cycle
            wr_ready <= axil_req.awvalid && axil_req.wvalid && !bvalid && !wr_ready;
            ar_ready <= axil_req.arvalid && !rvalid && !ar_ready;
            start    <= wr_en && ctrl_wr;
            if (wr_en) begin
                bvalid <= 1'b1;
                bresp  <= wr_resp;
            end else if (bvalid && axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_en) begin
                rvalid <= 1'b1;
                rdata  <= rd_data;
                rresp  <= rd_resp;
            end else if (rvalid && axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Operands and the command snapshot
    always_ff @(posedge clk) begin
        if (wr_en && axil_req.awaddr == `REG_OPERAND_A) begin
            if (axil_req.wstrb[0]) operand_a[7:0]  <= axil_req.wdata[7:0];
            if (axil_req.wstrb[1]) operand_a[15:8] <= axil_req.wdata[15:8];
        end
        if (wr_en && axil_req.awaddr == `REG_OPERAND_B) begin
            if (axil_req.wstrb[0]) operand_b.value[7:0]  <= axil_req.wdata[7:0];
            if (axil_req.wstrb[1]) operand_b.value[15:8] <= axil_req.wdata[15:8];
        end
        if (wr_en && ctrl_wr) begin
            cmd.op <= alu_op_e'(axil_req.wdata[1:0]);
            cmd.a  <= operand_a;
            cmd.b  <= operand_b;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done  <= 1'b0;
            res_q <= '0;
        end else if (start) begin
            done <= 1'b0;
        end else if (finish) begin
            done  <= 1'b1;
            res_q <= result;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_ready;
        axil_rsp.wready  = wr_ready;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = ar_ready;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
    end

endmodule

// ==== source/alu_exec_datapath.sv ====
/* Shared accumulator for shift capture, shift-and-add multiply and restoring divide.
   result shows the register values after the current edge; cmd must hold during an op. */
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_exec_datapath import alu_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  alu_cmd_t    cmd,
    input  exec_ctrl_t  ctrl,
    output alu_result_t result
);
    alu_word_t             acc;
    alu_word_t             quo;
    alu_word_t             opnd;
    logic                  dbz;
    alu_word_t             acc_nxt;
    alu_word_t             quo_nxt;
    logic                  dbz_nxt;
    alu_word_t             sh_result;
    alu_word_t             sh_overflow;
    logic [`ALU_WIDTH:0]   mul_sum;
    logic [`ALU_WIDTH:0]   div_rem;
    logic [`ALU_WIDTH:0]   div_diff;

    alu_shifter u_shifter (
        .a        (cmd.a),
        .ctrl     (cmd.b.shift),
        .arith    (cmd.op == OP_SHIFT_ARITH),
        .result   (sh_result),
        .overflow (sh_overflow)
    );

    // acc is the high product or remainder, quo the low product or quotient
    always_comb begin
        mul_sum  = {1'b0, acc} + (quo[0] ? {1'b0, opnd} : '0);
        div_rem  = {acc, quo[`ALU_WIDTH-1]};
        div_diff = div_rem - {1'b0, opnd};
        acc_nxt  = acc;
        quo_nxt  = quo;
        dbz_nxt  = dbz;
        if (ctrl.load_shift) begin
            acc_nxt = sh_overflow;
            quo_nxt = sh_result;
            dbz_nxt = 1'b0;
        end else if (ctrl.load_iter) begin
            acc_nxt = '0;
            quo_nxt = cmd.a;
            dbz_nxt = (cmd.op == OP_DIV) && (cmd.b.value == '0);
        end else if (ctrl.step) begin
            if (cmd.op == OP_MUL) begin
                acc_nxt = mul_sum[`ALU_WIDTH:1];
                quo_nxt = {mul_sum[0], quo[`ALU_WIDTH-1:1]};
            end else if (div_diff[`ALU_WIDTH]) begin
                // Borrow, so restore
                acc_nxt = div_rem[`ALU_WIDTH-1:0];
                quo_nxt = {quo[`ALU_WIDTH-2:0], 1'b0};
            end else begin
                acc_nxt = div_diff[`ALU_WIDTH-1:0];
                quo_nxt = {quo[`ALU_WIDTH-2:0], 1'b1};
            end
        end
    end

    always_ff @(posedge clk) begin
        acc <= acc_nxt;
        quo <= quo_nxt;
        if (ctrl.load_iter) begin
            opnd <= cmd.b.value;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dbz <= 1'b0;
        end else begin
            dbz <= dbz_nxt;
        end
    end

    // Zero divisor reads back as zero quotient and remainder
    assign result.lo          = dbz_nxt ? '0 : quo_nxt;
    assign result.hi          = dbz_nxt ? '0 : acc_nxt;
    assign result.div_by_zero = dbz_nxt;

endmodule

// ==== source/alu_params.svh ====
/* Widths, register map and response codes shared by the ALU sources.
   Register offsets assume a 5-bit byte address. */
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

`define ALU_WIDTH       16
`define ALU_STEP_W      5
`define AXIL_ADDR_W     5
`define AXIL_DATA_W     32

`define REG_OPERAND_A   5'h00
`define REG_OPERAND_B   5'h04
`define REG_CONTROL     5'h08
`define REG_STATUS      5'h0C
`define REG_RESULT_LO   5'h10
`define REG_RESULT_HI   5'h14

`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

// ==== source/alu_pkg.sv ====
/* Types shared by the ALU blocks and the testbench.
   Operand B is decoded either as a number or as a shift-control word. */
`include "alu_params.svh"

package alu_pkg;

    typedef logic [`ALU_WIDTH-1:0] alu_word_t;

    typedef enum logic [1:0] {
        OP_SHIFT_LOGICAL = 2'd0,
        OP_SHIFT_ARITH   = 2'd1,
        OP_MUL           = 2'd2,
        OP_DIV           = 2'd3
    } alu_op_e;

    // dir set means shift right
    typedef struct packed {
        logic                  fill;
        logic [`ALU_WIDTH-7:0] reserved;
        logic [3:0]            amount;
        logic                  dir;
    } shift_ctrl_t;

    typedef union packed {
        alu_word_t   value;
        shift_ctrl_t shift;
    } operand_b_u;

    typedef struct packed {
        alu_op_e    op;
        alu_word_t  a;
        operand_b_u b;
    } alu_cmd_t;

    typedef struct packed {
        alu_word_t lo;
        alu_word_t hi;
        logic      div_by_zero;
    } alu_result_t;

    // Strobes from the sequencer to the datapath
    typedef struct packed {
        logic load_shift;
        logic load_iter;
        logic step;
    } exec_ctrl_t;

    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0]   awaddr;
        logic                      awvalid;
        logic [`AXIL_DATA_W-1:0]   wdata;
        logic [`AXIL_DATA_W/8-1:0] wstrb;
        logic                      wvalid;
        logic                      bready;
        logic [`AXIL_ADDR_W-1:0]   araddr;
        logic                      arvalid;
        logic                      rready;
    } axil_req_t;

    typedef struct packed {
        logic                    awready;
        logic                    wready;
        logic                    bvalid;
        logic [1:0]              bresp;
        logic                    arready;
        logic                    rvalid;
        logic [`AXIL_DATA_W-1:0] rdata;
        logic [1:0]              rresp;
    } axil_rsp_t;

endpackage

// ==== source/alu_sequencer.sv ====
/* Operation FSM: shifts take one cycle, multiply and divide run until last_step.
   busy includes the start cycle itself. */
`timescale 1ns/10ps

module alu_sequencer import alu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    input  alu_op_e    op,
    input  logic       last_step,
    output exec_ctrl_t ctrl,
    output logic       cnt_load,
    output logic       cnt_en,
    output logic       busy,
    output logic       finish
);
    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        ITERATE
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   iterative;

    assign iterative = (op == OP_MUL) || (op == OP_DIV);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start) state_d = iterative ? ITERATE : SHIFT;
            SHIFT:   state_d = IDLE;
            ITERATE: if (last_step) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Iterative ops initialise on the start cycle so that 16 steps fit
    assign ctrl.load_iter  = (state_q == IDLE) && start && iterative;
    assign ctrl.load_shift = (state_q == SHIFT);
    assign ctrl.step       = (state_q == ITERATE);

    assign cnt_load = ctrl.load_iter;
    assign cnt_en   = (state_q == ITERATE);
    assign busy     = start || (state_q != IDLE);
    assign finish   = (state_q == SHIFT) || ((state_q == ITERATE) && last_step);

endmodule

// ==== source/alu_shifter.sv ====
/* Combinational shift unit. A zero amount passes a through with zero overflow.
   Arithmetic shifts ignore the fill bit of the control word. */
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_shifter import alu_pkg::*; (
    input  alu_word_t   a,
    input  shift_ctrl_t ctrl,
    input  logic        arith,
    output alu_word_t   result,
    output alu_word_t   overflow
);
    logic [2*`ALU_WIDTH-1:0] wide_l;
    alu_word_t               lo_mask;
    alu_word_t               hi_mask;
    logic                    fill_bit;

    always_comb begin
        // Sign fill only on an arithmetic right shift
        fill_bit = arith ? (ctrl.dir & a[`ALU_WIDTH-1]) : ctrl.fill;
        lo_mask  = ~({`ALU_WIDTH{1'b1}} << ctrl.amount);
        hi_mask  = ~({`ALU_WIDTH{1'b1}} >> ctrl.amount);
        wide_l   = {{`ALU_WIDTH{1'b0}}, a} << ctrl.amount;
        if (ctrl.dir) begin
            result   = (a >> ctrl.amount) | ({`ALU_WIDTH{fill_bit}} & hi_mask);
            // Dropped bits keep their original positions
            overflow = a & lo_mask;
        end else begin
            result   = wide_l[`ALU_WIDTH-1:0] | ({`ALU_WIDTH{fill_bit}} & lo_mask);
            overflow = wide_l[2*`ALU_WIDTH-1:`ALU_WIDTH];
        end
    end

endmodule

// ==== source/alu_step_counter.sv ====
/* Step counter for the iterative ops, holds at zero once reached. */
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_step_counter (
    input  logic clk,
    input  logic arst_n,
    input  logic load,
    input  logic en,
    output logic last_step
);
    logic [`ALU_STEP_W-1:0] count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (load) begin
            count <= `ALU_STEP_W'(`ALU_WIDTH - 1);
        end else if (en && count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign last_step = (count == '0);

endmodule

// ==== source/alu_top.sv ====
/* AXI4-Lite mapped 16-bit ALU. Shifts finish in one cycle,
   multiply and divide in sixteen. */
`timescale 1ns/10ps

module alu_top import alu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp
);
    logic        start;
    logic        busy;
    logic        finish;
    logic        cnt_load;
    logic        cnt_en;
    logic        last_step;
    alu_cmd_t    cmd;
    alu_result_t result;
    exec_ctrl_t  ctrl;

    alu_axil_regs u_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .busy     (busy),
        .finish   (finish),
        .result   (result),
        .start    (start),
        .cmd      (cmd)
    );

    alu_sequencer u_sequencer (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .op        (cmd.op),
        .last_step (last_step),
        .ctrl      (ctrl),
        .cnt_load  (cnt_load),
        .cnt_en    (cnt_en),
        .busy      (busy),
        .finish    (finish)
    );

    alu_step_counter u_step_counter (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (cnt_load),
        .en        (cnt_en),
        .last_step (last_step)
    );

    alu_exec_datapath u_datapath (
        .clk    (clk),
        .arst_n (arst_n),
        .cmd    (cmd),
        .ctrl   (ctrl),
        .result (result)
    );

endmodule

// ==== tb/alu_properties.sv ====
/* Handshake and sequencer assertions for alu_top, bound at the end of this file.
   All checks are off while arst_n is low. */
`timescale 1ns/10ps

module alu_properties import alu_pkg::*; (
    input logic       clk,
    input logic       arst_n,
    input axil_req_t  axil_req,
    input axil_rsp_t  axil_rsp,
    input logic       start,
    input logic       busy,
    input logic       finish,
    input exec_ctrl_t ctrl
);
    int fail_count = 0;

    // A response and its payload stay put until the master takes it
    bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
        else begin
            fail_count++;
            $error("bvalid or bresp changed before bready");
        end

    rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        axil_rsp.rvalid && !axil_req.rready
        |=> axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
        else begin
            fail_count++;
            $error("rvalid or read payload changed before rready");
        end

    busy_needs_start: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(busy) |-> start)
        else begin
            fail_count++;
            $error("busy rose without a start pulse");
        end

    finish_single: assert property (@(posedge clk) disable iff (!arst_n)
        finish |=> !finish)
        else begin
            fail_count++;
            $error("finish lasted longer than one cycle");
        end

    // Strobes only while an operation is in flight
    strobe_when_busy: assert property (@(posedge clk) disable iff (!arst_n)
        (|ctrl) |-> busy)
        else begin
            fail_count++;
            $error("Datapath strobe while the sequencer is idle");
        end

endmodule

bind alu_top alu_properties u_properties (
    .clk      (clk),
    .arst_n   (arst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .start    (start),
    .busy     (busy),
    .finish   (finish),
    .ctrl     (ctrl)
);

// ==== tb/alu_tb.sv ====
/* Random stimulus from a fixed seed, checked against a behavioural model.
   Stops at the first wrong value or timeout. */
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_tb import alu_pkg::*; ();
    localparam int HANDSHAKE_LIMIT = 20;
    localparam int POLL_LIMIT      = 40;
    localparam int OP_COUNT        = 200;

    logic      clk;
    logic      arst_n;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    int        seed;
    int        max_stall;
    logic      last_dbz;

    alu_top DUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    function automatic int pick_stall();
        logic [31:0] r;
        r = next_rand();
        pick_stall = (max_stall == 0) ? 0 : int'(r % (max_stall + 1));
    endfunction

    function automatic alu_result_t model_result(input alu_op_e op, input alu_word_t a,
                                                 input alu_word_t b);
        alu_result_t res;
        logic [31:0] prod;
        int          amt;
        logic        fill;
        res = '0;
        amt = int'(b[4:1]);
        case (op)
            OP_MUL: begin
                prod   = {16'h0, a} * {16'h0, b};
                res.lo = prod[15:0];
                res.hi = prod[31:16];
            end
            OP_DIV: begin
                if (b == '0) begin
                    res.div_by_zero = 1'b1;
                end else begin
                    res.lo = a / b;
                    res.hi = a % b;
                end
            end
            default: begin
                // Arithmetic: sign fill going right, zeros going left
                if (op == OP_SHIFT_ARITH) fill = b[0] ? a[15] : 1'b0;
                else fill = b[15];
                for (int i = 0; i < `ALU_WIDTH; i++) begin
                    if (b[0]) begin
                        res.lo[i] = (i + amt < `ALU_WIDTH) ? a[i + amt] : fill;
                        res.hi[i] = (i < amt) ? a[i] : 1'b0;
                    end else begin
                        res.lo[i] = (i >= amt) ? a[i - amt] : fill;
                        res.hi[i] = (i < amt) ? a[`ALU_WIDTH - amt + i] : 1'b0;
                    end
                end
            end
        endcase
        return res;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    // Bound assertion failures end the run as well
    always @(posedge clk) begin
        if (DUT.u_properties.fail_count != 0) begin
            report_failure("An assertion on the AXI handshake or the sequencer failed");
        end
    end

    task automatic check_word(input string name, input alu_word_t got, input alu_word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %b expected %b",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_status(input logic [`AXIL_DATA_W-1:0] got, input logic busy,
                                input logic done, input logic dbz);
        logic [`AXIL_DATA_W-1:0] exp;
        exp = {{(`AXIL_DATA_W-3){1'b0}}, dbz, done, busy};
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: STATUS got %h expected %h",
                                     $time, got, exp));
        end
    endtask

    task automatic write_reg(input logic [`AXIL_ADDR_W-1:0] addr,
                             input logic [`AXIL_DATA_W-1:0] data, output logic [1:0] resp);
        int waited;
        axil_req.awaddr  <= addr;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= '1;
        axil_req.awvalid <= 1'b1;
        axil_req.wvalid  <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > HANDSHAKE_LIMIT) report_failure("Write address and data never accepted");
        end while (!(axil_rsp.awready && axil_rsp.wready));
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > HANDSHAKE_LIMIT) report_failure("No write response arrived");
        end while (!axil_rsp.bvalid);
        // Hold the response off for a while
        repeat (pick_stall()) @(posedge clk);
        axil_req.bready <= 1'b1;
        @(posedge clk);
        resp = axil_rsp.bresp;
        axil_req.bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [`AXIL_ADDR_W-1:0] addr,
                            output logic [`AXIL_DATA_W-1:0] data, output logic [1:0] resp);
        int waited;
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > HANDSHAKE_LIMIT) report_failure("Read address never accepted");
        end while (!axil_rsp.arready);
        axil_req.arvalid <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > HANDSHAKE_LIMIT) report_failure("No read data arrived");
        end while (!axil_rsp.rvalid);
        repeat (pick_stall()) @(posedge clk);
        axil_req.rready <= 1'b1;
        @(posedge clk);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        axil_req.rready <= 1'b0;
    endtask

    task automatic wait_done(output logic [`AXIL_DATA_W-1:0] status);
        logic [1:0] resp;
        int         polls;
        polls = 0;
        do begin
            read_reg(`REG_STATUS, status, resp);
            check_resp("rresp STATUS", resp, `AXI_RESP_OKAY);
            polls++;
            if (polls > POLL_LIMIT) report_failure("Operation never completed, done stayed low");
        end while (!status[1]);
    endtask

    task automatic start_op(input alu_op_e op, input alu_word_t a, input alu_word_t b);
        logic [1:0] resp;
        write_reg(`REG_OPERAND_A, `AXIL_DATA_W'(a), resp);
        check_resp("bresp OPERAND_A", resp, `AXI_RESP_OKAY);
        write_reg(`REG_OPERAND_B, `AXIL_DATA_W'(b), resp);
        check_resp("bresp OPERAND_B", resp, `AXI_RESP_OKAY);
        write_reg(`REG_CONTROL, `AXIL_DATA_W'(op), resp);
        check_resp("bresp CONTROL", resp, `AXI_RESP_OKAY);
    endtask

    task automatic finish_op(input alu_result_t exp);
        logic [`AXIL_DATA_W-1:0] data;
        logic [1:0]              resp;
        wait_done(data);
        check_status(data, 1'b0, 1'b1, exp.div_by_zero);
        read_reg(`REG_RESULT_LO, data, resp);
        check_resp("rresp RESULT_LO", resp, `AXI_RESP_OKAY);
        check_word("RESULT_LO", data[15:0], exp.lo);
        check_word("RESULT_LO upper half", data[31:16], '0);
        read_reg(`REG_RESULT_HI, data, resp);
        check_resp("rresp RESULT_HI", resp, `AXI_RESP_OKAY);
        check_word("RESULT_HI", data[15:0], exp.hi);
        check_word("RESULT_HI upper half", data[31:16], '0);
        last_dbz = exp.div_by_zero;
    endtask

    task automatic run_op(input alu_op_e op, input alu_word_t a, input alu_word_t b);
        start_op(op, a, b);
        finish_op(model_result(op, a, b));
    endtask

    initial begin
        logic [31:0]             rnd_a;
        logic [31:0]             rnd_b;
        logic [`AXIL_DATA_W-1:0] data;
        logic [1:0]              resp;
        alu_word_t               divisor;
        seed      = 32'h65bb_4e31;
        max_stall = 3;
        last_dbz  = 1'b0;
        clk       = 1'b0;
        arst_n   <= 1'b0;
        axil_req <= '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        // Reset state and unmapped addresses
        read_reg(`REG_STATUS, data, resp);
        check_resp("rresp STATUS", resp, `AXI_RESP_OKAY);
        check_status(data, 1'b0, 1'b0, 1'b0);
        read_reg(5'h18, data, resp);
        check_resp("rresp unmapped", resp, `AXI_RESP_SLVERR);
        check_word("rdata unmapped low half", data[15:0], '0);
        check_word("rdata unmapped upper half", data[31:16], '0);
        write_reg(5'h1C, '1, resp);
        check_resp("bresp unmapped", resp, `AXI_RESP_SLVERR);

        repeat (OP_COUNT) begin
            rnd_a = next_rand();
            rnd_b = next_rand();
            run_op(rnd_a[16] ? OP_SHIFT_ARITH : OP_SHIFT_LOGICAL, rnd_a[15:0], rnd_b[15:0]);
        end
        repeat (OP_COUNT) begin
            rnd_a = next_rand();
            rnd_b = next_rand();
            run_op(OP_MUL, rnd_a[15:0], rnd_b[15:0]);
        end
        // Divides with some forced zero and small divisors
        repeat (OP_COUNT) begin
            rnd_a = next_rand();
            rnd_b = next_rand();
            divisor = rnd_b[20] ? {12'h0, rnd_b[3:0]} : rnd_b[15:0];
            if (rnd_b[18:16] == 3'd0) divisor = '0;
            run_op(OP_DIV, rnd_a[15:0], divisor);
        end

        // CONTROL write during a multiply is refused
        max_stall = 0;
        start_op(OP_MUL, 16'hbeef, 16'h0123);
        write_reg(`REG_CONTROL, `AXIL_DATA_W'(OP_DIV), resp);
        check_resp("bresp CONTROL while busy", resp, `AXI_RESP_SLVERR);
        read_reg(`REG_STATUS, data, resp);
        check_resp("rresp STATUS while busy", resp, `AXI_RESP_OKAY);
        check_status(data, 1'b1, 1'b0, last_dbz);
        finish_op(model_result(OP_MUL, 16'hbeef, 16'h0123));

        // Long response back-pressure on both channels
        max_stall = 12;
        repeat (40) begin
            rnd_a = next_rand();
            rnd_b = next_rand();
            run_op(alu_op_e'(rnd_a[17:16]), rnd_a[15:0], rnd_b[15:0]);
        end

        if (DUT.u_properties.fail_count != 0) begin
            report_failure("An assertion on the AXI handshake or the sequencer failed");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule
